// ==== list.f ====
hw/csr_pkg.sv
hw/csr_reg.sv
hw/csr_decode.sv
hw/csr_machine.sv
hw/csr_result.sv
hw/csr_unit.sv
verif/tb_csr_unit.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - hw/csr_pkg.sv
  - hw/csr_reg.sv
  - hw/csr_decode.sv
  - hw/csr_machine.sv
  - hw/csr_result.sv
  - hw/csr_unit.sv
  - target: simulation
    files:
      - verif/tb_csr_unit.sv

// ==== verif/tb_csr_unit.sv ====
`timescale 1ns/1ps

module tb_csr_unit import csr_pkg::*;
();

    localparam logic [11:0] A_MSTATUS  = 12'h300;
    localparam logic [11:0] A_MISA     = 12'h301;
    localparam logic [11:0] A_MIE      = 12'h304;
    localparam logic [11:0] A_MTVEC    = 12'h305;
    localparam logic [11:0] A_MSCRATCH = 12'h340;
    localparam logic [11:0] A_MEPC     = 12'h341;
    localparam logic [11:0] A_MCAUSE   = 12'h342;
    localparam logic [11:0] A_MIP      = 12'h344;
    localparam logic [11:0] A_UNKNOWN  = 12'h7c0;   // Unimplemented custom address

    localparam logic [2:0] F_RW  = 3'b001;
    localparam logic [2:0] F_RS  = 3'b010;
    localparam logic [2:0] F_RC  = 3'b011;
    localparam logic [2:0] F_RWI = 3'b101;
    localparam logic [2:0] F_RSI = 3'b110;
    localparam logic [2:0] F_RCI = 3'b111;

    localparam xlen_t EBREAK_WORD = 32'h0010_0073;
    localparam xlen_t MRET_WORD   = 32'h3020_0073;
    localparam int    DRAIN_LIMIT = 20;

    typedef struct packed {
        logic [31:0] due;       // Compare cycle of this result
        logic        wb;
        reg_idx_t    rd;
        xlen_t       data;
        logic        redir;
        xlen_t       pc;        // Byte address
    } expect_t;

    logic     i_clk;
    logic     i_reset_n;
    logic     i_valid;
    xlen_t    i_instr;
    pc_t      i_pc;
    xlen_t    i_rs1_data;
    logic     i_int_timer;
    logic     i_int_ext;
    logic     o_wb_valid;
    reg_idx_t o_wb_rd;
    xlen_t    o_wb_data;
    logic     o_redirect;
    pc_t      o_redirect_pc;

    expect_t     expect_q[$];
    logic [31:0] cycle;
    logic        checking;
    logic [15:0] lfsr_state;
    xlen_t       pc_byte;
    logic        irq_timer;
    logic        irq_ext;
    int          checks;
    int          errors;
    int          test_errors;
    int          tests;
    int          tests_failed;

    // CSR model state
    logic        m_mie;
    logic        m_mpie;
    xlen_t       m_ie;
    xlen_t       m_mtvec;
    xlen_t       m_mscratch;
    xlen_t       m_mtval;
    logic [2:0]  m_mcounteren;
    xlen_t       m_mepc;
    xlen_t       m_mcause;

    csr_unit #(.EXT_C(1'b1), .EXT_M(1'b1), .EXT_ZICNTR(1'b1)) i_csr_unit
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_valid       (i_valid),
        .i_instr       (i_instr),
        .i_pc          (i_pc),
        .i_rs1_data    (i_rs1_data),
        .i_int_timer   (i_int_timer),
        .i_int_ext     (i_int_ext),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic xlen_t random_word();
        xlen_t w;
        w = '0;
        for (int b = 0; b < 32; b++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic reg_idx_t random_imm();
        reg_idx_t v;
        v = '0;
        for (int b = 0; b < 5; b++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[3:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic xlen_t csr_instr(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                                        logic [11:0] addr);
        return {addr, rs1, f3, rd, 7'b1110011};
    endfunction

    // MXL 32 plus one bit per extension letter
    function automatic xlen_t misa_value();
        return (32'd1 << 30) | (32'd1 << ("I" - "A")) | (32'd1 << ("M" - "A")) |
               (32'd1 << ("C" - "A"));
    endfunction

    // Reference model called once per issued instruction
    function automatic expect_t model_expect(xlen_t instr, xlen_t pc, xlen_t rs1_val,
                                             logic int_timer, logic int_ext);
        expect_t     e;
        logic [2:0]  f3;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        logic [11:0] addr;
        logic        is_csr;
        logic        known;
        logic        take_int;
        xlen_t       old;
        xlen_t       operand;
        xlen_t       nv;
        cause_t      code;
        xlen_t       base;
        e       = '0;
        f3      = instr[14:12];
        rd      = instr[11:7];
        rs1     = instr[19:15];
        addr    = instr[31:20];
        is_csr  = (instr[6:0] == 7'b1110011) && (f3[1:0] != 2'b00);
        known   = 1'b1;
        old     = '0;
        case (addr)
            A_MSTATUS:  old = {24'b0, m_mpie, 3'b0, m_mie, 3'b0};
            A_MISA:     old = misa_value();
            A_MIE:      old = m_ie;
            A_MTVEC:    old = m_mtvec;
            12'h306:    old = {29'b0, m_mcounteren};
            12'h310:    old = '0;                     // mstatush
            A_MSCRATCH: old = m_mscratch;
            A_MEPC:     old = m_mepc;
            A_MCAUSE:   old = m_mcause;
            12'h343:    old = m_mtval;
            A_MIP:      old = {20'b0, int_ext, 3'b0, int_timer, 7'b0};
            default:    known = 1'b0;
        endcase
        take_int = m_mie && ((int_ext && m_ie[11]) || (int_timer && m_ie[7]));
        if (take_int || (is_csr && !known) || (instr == EBREAK_WORD))
        begin
            if (take_int)
                code = (int_ext && m_ie[11]) ? 4'd11 : 4'd7;
            else
                code = (is_csr && !known) ? 4'd2 : 4'd3;
            base    = {m_mtvec[31:2], 2'b00};
            e.redir = 1'b1;
            e.pc    = (take_int && (m_mtvec[1:0] == 2'b01)) ? base + 4 * code : base;
            m_mepc   = pc;
            m_mcause = {take_int, 27'b0, code};
            m_mpie   = m_mie;
            m_mie    = 1'b0;
        end
        else if (instr == MRET_WORD)
        begin
            e.redir = 1'b1;
            e.pc    = m_mepc;
            m_mie   = m_mpie;
            m_mpie  = 1'b1;
        end
        else if (is_csr)
        begin
            operand = f3[2] ? {27'b0, rs1} : rs1_val;
            if (f3[1:0] == 2'b01)
                nv = operand;
            else if (f3[1:0] == 2'b10)
                nv = old | operand;
            else
                nv = old & ~operand;
            if ((f3[1:0] == 2'b01) || (rs1 != '0))   // Set and clear need a nonzero rs1 field
            begin
                case (addr)
                    A_MSTATUS:
                    begin
                        m_mie  = nv[3];
                        m_mpie = nv[7];
                    end
                    A_MIE:      m_ie = nv & 32'h0000_0888;
                    A_MTVEC:    m_mtvec = nv;
                    12'h306:    m_mcounteren = nv[2:0];
                    A_MSCRATCH: m_mscratch = nv;
                    A_MEPC:     m_mepc = nv & ~32'h1;
                    A_MCAUSE:   m_mcause = nv & 32'h8000_000f;
                    12'h343:    m_mtval = nv;
                    default:    ;
                endcase
            end
            e.wb   = (rd != '0);
            e.rd   = rd;
            e.data = old;
        end
        return e;
    endfunction

    task automatic check_value(string what, xlen_t got, xlen_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            test_errors++;
            $display("mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic issue(xlen_t instr, xlen_t rs1_val);
        expect_t e;
        @(posedge i_clk);
        e     = model_expect(instr, pc_byte, rs1_val, irq_timer, irq_ext);
        e.due = cycle + 3;      // Falling edge after the second rising edge
        i_valid    <= 1'b1;
        i_instr    <= instr;
        i_pc       <= pc_byte[31:1];
        i_rs1_data <= rs1_val;
        expect_q.push_back(e);
        pc_byte = pc_byte + 4;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge i_clk);
        i_valid <= 1'b0;
        while ((expect_q.size() != 0) && (waited < DRAIN_LIMIT))
        begin
            @(posedge i_clk);
            waited++;
        end
        if (expect_q.size() != 0)
        begin
            $display("timeout: %0d results still pending after %0d cycles",
                     expect_q.size(), waited);
            errors++;
            test_errors++;
            expect_q.delete();
        end
    endtask

    task automatic set_irq(logic timer, logic ext);
        drain();
        @(posedge i_clk);
        i_int_timer <= timer;
        i_int_ext   <= ext;
        irq_timer = timer;
        irq_ext   = ext;
    endtask

    task automatic end_test(string name);
        drain();
        tests++;
        if (test_errors != 0)
            tests_failed++;
        $display("test %0d %s: %0d errors", tests, name, test_errors);
        test_errors = 0;
    endtask

    task automatic run_rw_forms(logic [11:0] addr);
        issue(csr_instr(F_RW, 5'd1, 5'd7, addr), random_word());
        issue(csr_instr(F_RS, 5'd2, 5'd7, addr), random_word());
        issue(csr_instr(F_RC, 5'd3, 5'd7, addr), random_word());
        issue(csr_instr(F_RWI, 5'd4, random_imm(), addr), random_word());
        issue(csr_instr(F_RSI, 5'd5, random_imm(), addr), random_word());
        issue(csr_instr(F_RCI, 5'd6, random_imm(), addr), random_word());
        issue(csr_instr(F_RW, 5'd0, 5'd7, addr), random_word());   // No write-back
        issue(csr_instr(F_RS, 5'd9, 5'd0, addr), random_word());
    endtask

    // Compare process
    initial
    begin
        expect_t e;
        cycle = '0;
        forever
        begin
            @(negedge i_clk);
            cycle = cycle + 1;
            if (checking)
            begin
                e = '0;
                if ((expect_q.size() != 0) && (expect_q[0].due == cycle))
                    e = expect_q.pop_front();
                check_value("wb_valid", o_wb_valid, e.wb);
                if (e.wb)
                begin
                    check_value("wb_rd", o_wb_rd, e.rd);
                    check_value("wb_data", o_wb_data, e.data);
                end
                check_value("redirect", o_redirect, e.redir);
                if (e.redir)
                    check_value("redirect_pc", {o_redirect_pc, 1'b0}, e.pc);
            end
        end
    end

    initial
    begin
        i_reset_n   = 1'b0;
        i_valid     = 1'b0;
        i_instr     = '0;
        i_pc        = '0;
        i_rs1_data  = '0;
        i_int_timer = 1'b0;
        i_int_ext   = 1'b0;
        checking    = 1'b0;
        lfsr_state  = 16'd8891;
        pc_byte     = 32'h0000_1000;
        irq_timer   = 1'b0;
        irq_ext     = 1'b0;
        checks = 0;
        errors = 0;
        test_errors  = 0;
        tests        = 0;
        tests_failed = 0;
        m_mie = 1'b0;
        m_mpie = 1'b0;
        m_ie = '0;
        m_mtvec = '0;
        m_mscratch = '0;
        m_mtval = '0;
        m_mcounteren = '0;
        m_mepc = '0;
        m_mcause = '0;

        repeat (10) @(posedge i_clk);
        i_reset_n <= 1'b1;
        checking = 1'b1;

        issue(csr_instr(F_RS, 5'd5, 5'd0, A_MISA), '0);
        issue(csr_instr(F_RS, 5'd5, 5'd0, A_MSTATUS), '0);
        issue(csr_instr(F_RS, 5'd5, 5'd0, A_MIE), '0);
        issue(csr_instr(F_RS, 5'd5, 5'd0, A_MTVEC), '0);
        issue(csr_instr(F_RS, 5'd5, 5'd0, A_MEPC), '0);
        issue(csr_instr(F_RS, 5'd5, 5'd0, A_MCAUSE), '0);
        end_test("reset values");

        run_rw_forms(A_MSCRATCH);
        run_rw_forms(A_MTVEC);
        end_test("read write forms");

        issue(csr_instr(F_RW, 5'd1, 5'd7, A_MSCRATCH), random_word());
        issue(csr_instr(F_RS, 5'd2, 5'd0, A_MSCRATCH), random_word());   // rs1 x0
        issue(csr_instr(F_RC, 5'd3, 5'd0, A_MSCRATCH), random_word());
        issue(csr_instr(F_RS, 5'd4, 5'd0, A_MSCRATCH), '0);
        issue(csr_instr(F_RW, 5'd0, 5'd7, A_MTVEC), 32'h0000_0100);
        issue(csr_instr(F_RW, 5'd3, 5'd7, A_UNKNOWN), random_word());
        issue(csr_instr(F_RS, 5'd4, 5'd0, A_MCAUSE), '0);
        end_test("x0 operand and illegal address");

        issue(csr_instr(F_RW, 5'd0, 5'd7, A_MTVEC), 32'h0000_0200);
        issue(csr_instr(F_RSI, 5'd0, 5'd8, A_MSTATUS), '0);             // Set MIE
        issue(EBREAK_WORD, '0);
        issue(csr_instr(F_RS, 5'd5, 5'd0, A_MEPC), '0);
        issue(csr_instr(F_RS, 5'd6, 5'd0, A_MCAUSE), '0);
        issue(csr_instr(F_RS, 5'd7, 5'd0, A_MSTATUS), '0);
        issue(MRET_WORD, '0);
        issue(csr_instr(F_RS, 5'd8, 5'd0, A_MSTATUS), '0);
        end_test("ebreak and mret");

        issue(csr_instr(F_RW, 5'd0, 5'd7, A_MTVEC), 32'h0000_0301);      // Vectored
        issue(csr_instr(F_RS, 5'd0, 5'd6, A_MIE), 32'h0000_0080);        // MTIE
        issue(csr_instr(F_RSI, 5'd0, 5'd8, A_MSTATUS), '0);
        set_irq(1'b1, 1'b0);
        issue(csr_instr(F_RS, 5'd5, 5'd0, A_MSCRATCH), '0);
        issue(csr_instr(F_RS, 5'd6, 5'd0, A_MCAUSE), '0);
        issue(csr_instr(F_RC, 5'd0, 5'd6, A_MIE), 32'h0000_0080);
        issue(csr_instr(F_RSI, 5'd0, 5'd8, A_MSTATUS), '0);
        issue(csr_instr(F_RS, 5'd7, 5'd0, A_MIP), '0);
        issue(csr_instr(F_RS, 5'd8, 5'd0, A_MSTATUS), '0);
        set_irq(1'b0, 1'b0);
        end_test("timer interrupt");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests_failed, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== hw/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit import csr_pkg::*;
#(
    parameter bit EXT_C      = 1'b1,
    parameter bit EXT_M      = 1'b1,
    parameter bit EXT_ZICNTR = 1'b1
)
(
    input  logic     i_clk,
    input  logic     i_reset_n,
    input  logic     i_valid,
    input  xlen_t    i_instr,
    input  pc_t      i_pc,
    input  xlen_t    i_rs1_data,
    input  logic     i_int_timer,
    input  logic     i_int_ext,
    output logic     o_wb_valid,
    output reg_idx_t o_wb_rd,
    output xlen_t    o_wb_data,
    output logic     o_redirect,
    output pc_t      o_redirect_pc
);

    csr_req_t  req;       // Registered decode output
    csr_exec_t exec;      // Combinational execute outcome

    csr_decode u_decode
    (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_valid    (i_valid),
        .i_instr    (i_instr),
        .i_pc       (i_pc),
        .i_rs1_data (i_rs1_data),
        .o_req      (req)
    );

    csr_machine
    #(
        .EXT_C      (EXT_C),
        .EXT_M      (EXT_M),
        .EXT_ZICNTR (EXT_ZICNTR)
    )
    u_machine
    (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_req       (req),
        .i_int_timer (i_int_timer),
        .i_int_ext   (i_int_ext),
        .o_exec      (exec)
    );

    csr_result u_result
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_exec        (exec),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

endmodule

// ==== hw/csr_result.sv ====
`timescale 1ns/1ps

module csr_result import csr_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset_n,
    input  csr_exec_t i_exec,
    output logic      o_wb_valid,
    output reg_idx_t  o_wb_rd,
    output xlen_t     o_wb_data,
    output logic      o_redirect,
    output pc_t       o_redirect_pc
);

    logic wb_take;
    logic redirect_take;
    pc_t  redirect_target;

    // x0 writes are dropped here, the CSR side effect still happened
    assign wb_take       = i_exec.valid & i_exec.rd_write & (i_exec.rd != '0);
    assign redirect_take = i_exec.valid & (i_exec.trap | i_exec.mret);

    always_comb
    begin
        if (i_exec.trap)
            redirect_target = i_exec.trap_pc;
        else
            redirect_target = i_exec.ret_pc;   // mret back to mepc
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_wb_valid <= 1'b0;
            o_redirect <= 1'b0;
        end
        else
        begin
            o_wb_valid <= wb_take;
            o_redirect <= redirect_take;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_wb_rd       <= i_exec.rd;
        o_wb_data     <= i_exec.old_data;
        o_redirect_pc <= redirect_target;
    end

endmodule

// ==== hw/csr_machine.sv ====
`timescale 1ns/1ps

module csr_machine import csr_pkg::*;
#(
    parameter bit EXT_C      = 1'b1,
    parameter bit EXT_M      = 1'b1,
    parameter bit EXT_ZICNTR = 1'b1
)
(
    input  logic      i_clk,
    input  logic      i_reset_n,
    input  csr_req_t  i_req,
    input  logic      i_int_timer,
    input  logic      i_int_ext,
    output csr_exec_t o_exec
);

    logic   mstatus_mie;
    logic   mstatus_mpie;
    logic   mie_meie;
    logic   mie_mtie;
    logic   mie_msie;
    pc_t    mepc_q;
    logic   mcause_int_q;
    cause_t mcause_code_q;

    logic   irq_ext;
    logic   irq_timer;
    logic   take_int;
    logic   take_exc;
    logic   take_trap;
    logic   take_mret;
    logic   op_en;
    cause_t trap_code;

    logic   sel_mstatus;
    logic   sel_mie;
    logic   sel_mtvec;
    logic   sel_mcounteren;
    logic   sel_mscratch;
    logic   sel_mepc;
    logic   sel_mcause;
    logic   sel_mtval;

    xlen_t  mstatus_data;
    xlen_t  misa_data;
    xlen_t  mie_data;
    xlen_t  mip_data;
    xlen_t  mepc_data;
    xlen_t  mcause_data;
    xlen_t  mtvec_data;
    xlen_t  mscratch_data;
    xlen_t  mtval_data;
    xlen_t  mcounteren_data;
    xlen_t  mstatus_new;
    xlen_t  mie_new;
    xlen_t  mepc_new;
    xlen_t  mcause_new;
    xlen_t  read_data;
    xlen_t  vec_base;
    xlen_t  vec_target;

    // Interrupts take precedence over whatever the request holds
    assign irq_ext   = i_int_ext & mie_meie;
    assign irq_timer = i_int_timer & mie_mtie;
    assign take_int  = i_req.valid & mstatus_mie & (irq_ext | irq_timer);
    assign take_exc  = i_req.valid & ~take_int & (i_req.illegal | i_req.ebreak);
    assign take_trap = take_int | take_exc;
    assign take_mret = i_req.valid & i_req.mret & ~take_int;
    assign op_en     = i_req.valid & i_req.is_csr & ~take_trap;   // Trap drops the op

    always_comb
    begin
        if (take_int)
            trap_code = irq_ext ? CAUSE_M_EXT : CAUSE_M_TIMER;   // External wins
        else if (i_req.illegal)
            trap_code = CAUSE_ILLEGAL;
        else
            trap_code = CAUSE_BREAKPOINT;
    end

    assign sel_mstatus    = op_en && (i_req.idx == CSR_IDX_MSTATUS);
    assign sel_mie        = op_en && (i_req.idx == CSR_IDX_MIE);
    assign sel_mtvec      = op_en && (i_req.idx == CSR_IDX_MTVEC);
    assign sel_mcounteren = op_en && (i_req.idx == CSR_IDX_MCOUNTEREN);
    assign sel_mscratch   = op_en && (i_req.idx == CSR_IDX_MSCRATCH);
    assign sel_mepc       = op_en && (i_req.idx == CSR_IDX_MEPC);
    assign sel_mcause     = op_en && (i_req.idx == CSR_IDX_MCAUSE);
    assign sel_mtval      = op_en && (i_req.idx == CSR_IDX_MTVAL);

    always_comb
    begin
        mstatus_data = '0;
        mstatus_data[MSTATUS_MIE_BIT]  = mstatus_mie;
        mstatus_data[MSTATUS_MPIE_BIT] = mstatus_mpie;
        mie_data = '0;
        mie_data[MIE_MSIE_BIT] = mie_msie;
        mie_data[MIE_MTIE_BIT] = mie_mtie;
        mie_data[MIE_MEIE_BIT] = mie_meie;
        mip_data = '0;                         // No software interrupt pending bit
        mip_data[MIE_MTIE_BIT] = i_int_timer;
        mip_data[MIE_MEIE_BIT] = i_int_ext;
    end

    // MXL 32, then M, I and C
    assign misa_data   = {2'b01, 4'b0, 13'b0, EXT_M, 3'b0, 1'b1, 5'b0, EXT_C, 2'b0};
    assign mepc_data   = {mepc_q, 1'b0};
    assign mcause_data = {mcause_int_q, 27'b0, mcause_code_q};

    assign mstatus_new = csr_apply(mstatus_data, i_req.data, i_req.write, i_req.set, i_req.clear);
    assign mie_new     = csr_apply(mie_data, i_req.data, i_req.write, i_req.set, i_req.clear);
    assign mepc_new    = csr_apply(mepc_data, i_req.data, i_req.write, i_req.set, i_req.clear);
    assign mcause_new  = csr_apply(mcause_data, i_req.data, i_req.write, i_req.set, i_req.clear);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
        end
        else if (take_trap)
        begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
        end
        else if (take_mret)
        begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end
        else if (sel_mstatus)
        begin
            mstatus_mie  <= mstatus_new[MSTATUS_MIE_BIT];
            mstatus_mpie <= mstatus_new[MSTATUS_MPIE_BIT];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            mie_meie <= 1'b0;
            mie_mtie <= 1'b0;
            mie_msie <= 1'b0;
        end
        else if (sel_mie)
        begin
            mie_meie <= mie_new[MIE_MEIE_BIT];
            mie_mtie <= mie_new[MIE_MTIE_BIT];
            mie_msie <= mie_new[MIE_MSIE_BIT];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            mepc_q        <= '0;
            mcause_int_q  <= 1'b0;
            mcause_code_q <= '0;
        end
        else if (take_trap)
        begin
            mepc_q        <= i_req.pc;
            mcause_int_q  <= take_int;
            mcause_code_q <= trap_code;
        end
        else
        begin
            if (sel_mepc)
                mepc_q <= mepc_new[31:1];
            if (sel_mcause)
            begin
                mcause_int_q  <= mcause_new[31];
                mcause_code_q <= mcause_new[3:0];
            end
        end
    end

    csr_reg #(.WIDTH(32)) u_mtvec
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_sel     (sel_mtvec),
        .i_data    (i_req.data),
        .i_write   (i_req.write),
        .i_set     (i_req.set),
        .i_clear   (i_req.clear),
        .o_data    (mtvec_data)
    );

    csr_reg #(.WIDTH(32)) u_mscratch
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_sel     (sel_mscratch),
        .i_data    (i_req.data),
        .i_write   (i_req.write),
        .i_set     (i_req.set),
        .i_clear   (i_req.clear),
        .o_data    (mscratch_data)
    );

    csr_reg #(.WIDTH(32)) u_mtval
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_sel     (sel_mtval),
        .i_data    (i_req.data),
        .i_write   (i_req.write),
        .i_set     (i_req.set),
        .i_clear   (i_req.clear),
        .o_data    (mtval_data)
    );

    generate
        if (EXT_ZICNTR)
        begin : g_mcounteren
            // CY, TM and IR enables only
            csr_reg #(.WIDTH(3)) u_mcounteren
            (
                .i_clk     (i_clk),
                .i_reset_n (i_reset_n),
                .i_sel     (sel_mcounteren),
                .i_data    (i_req.data),
                .i_write   (i_req.write),
                .i_set     (i_req.set),
                .i_clear   (i_req.clear),
                .o_data    (mcounteren_data)
            );
        end
        else
        begin : g_no_mcounteren
            assign mcounteren_data = '0;
        end
    endgenerate

    always_comb
    begin
        case (i_req.idx)
            CSR_IDX_MSTATUS:    read_data = mstatus_data;
            CSR_IDX_MISA:       read_data = misa_data;
            CSR_IDX_MIE:        read_data = mie_data;
            CSR_IDX_MTVEC:      read_data = mtvec_data;
            CSR_IDX_MCOUNTEREN: read_data = mcounteren_data;
            CSR_IDX_MSTATUSH:   read_data = '0;      // Little endian, nothing stored
            CSR_IDX_MSCRATCH:   read_data = mscratch_data;
            CSR_IDX_MEPC:       read_data = mepc_data;
            CSR_IDX_MCAUSE:     read_data = mcause_data;
            CSR_IDX_MTVAL:      read_data = mtval_data;
            CSR_IDX_MIP:        read_data = mip_data;
            default:            read_data = '0;
        endcase
    end

    // Vectored mode offsets interrupts only, exceptions use the base
    assign vec_base   = {mtvec_data[31:2], 2'b00};
    assign vec_target = (take_int && (mtvec_data[1:0] == MTVEC_MODE_VECTORED)) ?
                        vec_base + {26'b0, trap_code, 2'b00} : vec_base;

    always_comb
    begin
        o_exec.valid    = i_req.valid;
        o_exec.rd       = i_req.rd;
        o_exec.rd_write = op_en;
        o_exec.old_data = read_data;
        o_exec.trap     = take_trap;
        o_exec.mret     = take_mret;
        o_exec.trap_pc  = vec_target[31:1];
        o_exec.ret_pc   = mepc_q;
    end

endmodule

// ==== hw/csr_decode.sv ====
`timescale 1ns/1ps

module csr_decode import csr_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset_n,
    input  logic     i_valid,
    input  xlen_t    i_instr,
    input  pc_t      i_pc,
    input  xlen_t    i_rs1_data,
    output csr_req_t o_req
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    csr_addr_t  addr;
    csr_op_t    op;
    logic       is_csr;
    logic       rs1_nz;
    logic       known;
    csr_idx_t   idx;
    csr_req_t   req_d;

    assign opcode = i_instr[6:0];
    assign rd     = i_instr[11:7];
    assign funct3 = i_instr[14:12];
    assign rs1    = i_instr[19:15];      // Also the uimm field
    assign addr   = i_instr[31:20];
    assign op     = funct3[1:0];
    assign rs1_nz = (rs1 != '0);
    assign idx    = addr[7:0];           // Low byte is the compact index

    // funct3 000 and 100 are not CSR accesses
    assign is_csr = (opcode == OPCODE_SYSTEM) && (op != CSR_OP_NONE);

    always_comb
    begin
        case (addr)
            CSR_ADDR_MSTATUS,
            CSR_ADDR_MISA,
            CSR_ADDR_MIE,
            CSR_ADDR_MTVEC,
            CSR_ADDR_MCOUNTEREN,
            CSR_ADDR_MSTATUSH,
            CSR_ADDR_MSCRATCH,
            CSR_ADDR_MEPC,
            CSR_ADDR_MCAUSE,
            CSR_ADDR_MTVAL,
            CSR_ADDR_MIP:        known = 1'b1;
            default:             known = 1'b0;
        endcase
    end

    always_comb
    begin
        req_d.valid   = i_valid;
        req_d.pc      = i_pc;
        req_d.rd      = rd;
        req_d.idx     = idx;
        req_d.data    = funct3[2] ? xlen_t'(rs1) : i_rs1_data;  // Immediate forms
        req_d.write   = is_csr && (op == CSR_OP_RW);
        req_d.set     = is_csr && (op == CSR_OP_RS) && rs1_nz;
        req_d.clear   = is_csr && (op == CSR_OP_RC) && rs1_nz;
        req_d.is_csr  = is_csr;
        req_d.illegal = is_csr && !known;
        req_d.ebreak  = (i_instr == INSTR_EBREAK);
        req_d.mret    = (i_instr == INSTR_MRET);
    end

    always_ff @(posedge i_clk)
    begin
        o_req <= req_d;
        if (!i_reset_n)
            o_req.valid <= 1'b0;
    end

endmodule

// ==== hw/csr_reg.sv ====
`timescale 1ns/1ps

module csr_reg import csr_pkg::*;
#(
    parameter int WIDTH = 32
)
(
    input  logic  i_clk,
    input  logic  i_reset_n,
    input  logic  i_sel,
    input  xlen_t i_data,
    input  logic  i_write,
    input  logic  i_set,
    input  logic  i_clear,
    output xlen_t o_data
);

    logic [WIDTH-1:0] value_q;
    xlen_t            value_next;

    assign value_next = csr_apply(xlen_t'(value_q), i_data, i_write, i_set, i_clear);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            value_q <= '0;
        else if (i_sel)
            value_q <= value_next[WIDTH-1:0];   // Upper bits are not stored
    end

    assign o_data = xlen_t'(value_q);

endmodule

// ==== hw/csr_pkg.sv ====
package csr_pkg;

    typedef logic [31:0] xlen_t;      // One data word
    typedef logic [31:1] pc_t;        // Instruction address, bit 0 implied zero
    typedef logic [11:0] csr_addr_t;  // Architectural CSR address
    typedef logic [7:0]  csr_idx_t;   // Compact index, low byte of the address
    typedef logic [4:0]  reg_idx_t;   // Register file index
    typedef logic [3:0]  cause_t;     // mcause code field
    typedef logic [1:0]  csr_op_t;    // Low bits of funct3

    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;
    localparam xlen_t      INSTR_EBREAK  = 32'h0010_0073;
    localparam xlen_t      INSTR_MRET    = 32'h3020_0073;

    localparam csr_op_t CSR_OP_NONE = 2'b00;  // Not a CSR access
    localparam csr_op_t CSR_OP_RW   = 2'b01;
    localparam csr_op_t CSR_OP_RS   = 2'b10;
    localparam csr_op_t CSR_OP_RC   = 2'b11;

    localparam csr_addr_t CSR_ADDR_MSTATUS    = 12'h300;
    localparam csr_addr_t CSR_ADDR_MISA       = 12'h301;
    localparam csr_addr_t CSR_ADDR_MIE        = 12'h304;
    localparam csr_addr_t CSR_ADDR_MTVEC      = 12'h305;
    localparam csr_addr_t CSR_ADDR_MCOUNTEREN = 12'h306;
    localparam csr_addr_t CSR_ADDR_MSTATUSH   = 12'h310;
    localparam csr_addr_t CSR_ADDR_MSCRATCH   = 12'h340;
    localparam csr_addr_t CSR_ADDR_MEPC       = 12'h341;
    localparam csr_addr_t CSR_ADDR_MCAUSE     = 12'h342;
    localparam csr_addr_t CSR_ADDR_MTVAL      = 12'h343;
    localparam csr_addr_t CSR_ADDR_MIP        = 12'h344;

    localparam csr_idx_t CSR_IDX_MSTATUS    = 8'h00;
    localparam csr_idx_t CSR_IDX_MISA       = 8'h01;
    localparam csr_idx_t CSR_IDX_MIE        = 8'h04;
    localparam csr_idx_t CSR_IDX_MTVEC      = 8'h05;
    localparam csr_idx_t CSR_IDX_MCOUNTEREN = 8'h06;
    localparam csr_idx_t CSR_IDX_MSTATUSH   = 8'h10;
    localparam csr_idx_t CSR_IDX_MSCRATCH   = 8'h40;
    localparam csr_idx_t CSR_IDX_MEPC       = 8'h41;
    localparam csr_idx_t CSR_IDX_MCAUSE     = 8'h42;
    localparam csr_idx_t CSR_IDX_MTVAL      = 8'h43;
    localparam csr_idx_t CSR_IDX_MIP        = 8'h44;

    localparam cause_t CAUSE_ILLEGAL    = 4'd2;
    localparam cause_t CAUSE_BREAKPOINT = 4'd3;
    localparam cause_t CAUSE_M_TIMER    = 4'd7;
    localparam cause_t CAUSE_M_EXT      = 4'd11;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MIE_MSIE_BIT     = 3;   // Same positions in mip
    localparam int MIE_MTIE_BIT     = 7;
    localparam int MIE_MEIE_BIT     = 11;

    localparam logic [1:0] MTVEC_MODE_VECTORED = 2'b01;

    typedef struct packed {
        logic     valid;
        pc_t      pc;
        reg_idx_t rd;
        csr_idx_t idx;
        xlen_t    data;     // rs1 value or zero-extended immediate
        logic     write;
        logic     set;
        logic     clear;
        logic     is_csr;
        logic     illegal;
        logic     ebreak;
        logic     mret;
    } csr_req_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     rd_write;
        xlen_t    old_data;
        logic     trap;
        logic     mret;
        pc_t      trap_pc;
        pc_t      ret_pc;
    } csr_exec_t;

    // Write, set or clear one CSR image; no operation keeps the old value
    function automatic xlen_t csr_apply(
        xlen_t old_val,
        xlen_t data,
        logic  wr,
        logic  st,
        logic  cl
    );
        xlen_t result;
        result = old_val;
        if (wr)
            result = data;
        else if (st)
            result = old_val | data;
        else if (cl)
            result = old_val & ~data;
        return result;
    endfunction

endpackage
